// ==== source/spio_pkg.sv ====
package spio_pkg;

  //////////////////////////////////////////////////
  // Link and packet types
  //////////////////////////////////////////////////
  typedef logic [6:0]  code_t;                           // Raw state of the seven link wires
  typedef logic [71:0] packet_t;                         // Key/header in 39:0, payload in 71:40

  localparam int SHORT_SYMBOLS = 10;                     // Data symbols in a short packet
  localparam int LONG_SYMBOLS  = 18;                     // Data symbols in a long packet

  // Wishbone word addresses
  localparam logic [1:0] ADR_STATUS = 2'd0;              // Not empty, full, drop count
  localparam logic [1:0] ADR_WORD0  = 2'd1;              // Head packet bits 31:0
  localparam logic [1:0] ADR_WORD1  = 2'd2;              // Head packet bits 63:32
  localparam logic [1:0] ADR_WORD2  = 2'd3;              // Head packet bits 71:64, pops

  localparam code_t EOP_CODE = 7'b1100000;               // End-of-packet wire pair

  //////////////////////////////////////////////////
  // Symbol encode and decode
  //////////////////////////////////////////////////
  function automatic code_t nibble_code(input logic [3:0] nibble);
    case (nibble)
      4'd0:    return 7'b0010001;
      4'd1:    return 7'b0010010;
      4'd2:    return 7'b0010100;
      4'd3:    return 7'b0011000;
      4'd4:    return 7'b0100001;
      4'd5:    return 7'b0100010;
      4'd6:    return 7'b0100100;
      4'd7:    return 7'b0101000;
      4'd8:    return 7'b1000001;
      4'd9:    return 7'b1000010;
      4'd10:   return 7'b1000100;
      4'd11:   return 7'b1001000;
      4'd12:   return 7'b0000011;
      4'd13:   return 7'b0000110;
      4'd14:   return 7'b0001100;
      default: return 7'b0001001;                        // Nibble 15
    endcase
  endfunction

  // Diff is current code XOR last acknowledged code
  function automatic void decode_symbol(input code_t diff, output logic [3:0] nibble,
                                        output logic eop, output logic oob, output logic tom);
    logic hit;
    int   i;
    hit    = 1'b0;
    nibble = 4'd0;
    eop    = 1'b0;
    oob    = 1'b0;
    tom    = 1'b0;
    if ($countones(diff) >= 2) begin                     // Fewer wires means symbol still in flight
      tom = 1'b1;
      if (diff == EOP_CODE) begin
        eop = 1'b1;
      end else begin
        for (i = 0; i < 16; i++) begin                   // Reverse lookup of the encode table
          if (diff == nibble_code(4'(i))) begin
            nibble = 4'(i);
            hit    = 1'b1;
          end
        end
        oob = ~hit;                                      // Three or more wires, or unused pair
      end
    end
  endfunction

endpackage

// ==== source/spio_link_sync.sv ====
`timescale 1ns/1ps

module spio_link_sync #(
  parameter int SYNC_STAGES = 2                          // Flops per wire
) (
  input  logic               clk,
  input  logic               reset,
  input  spio_pkg::code_t    data_2of7,                  // Asynchronous link wires
  output spio_pkg::code_t    sync_code                   // Safe to decode
);

  spio_pkg::code_t sync_q [SYNC_STAGES];                 // Stage 0 sees the raw wires

  //////////////////////////////////////////////////
  // Synchronizer chain
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int s = 0; s < SYNC_STAGES; s++) begin
        sync_q[s] <= '0;
      end
    end else begin
      sync_q[0] <= data_2of7;                            // May go metastable here
      for (int s = 1; s < SYNC_STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];                        // Settle through the rest
      end
    end
  end

  assign sync_code = sync_q[SYNC_STAGES-1];              // Last stage feeds the decoder

endmodule

// ==== source/spio_packet_assembler.sv ====
`timescale 1ns/1ps

module spio_packet_assembler (
  input  logic              clk,
  input  logic              reset,
  input  spio_pkg::code_t   sync_code,                   // Synchronized link wires
  input  logic              fifo_full,                   // Back-pressure from the FIFO
  output logic              data_ack,                    // Toggles once per accepted symbol
  output logic              fifo_write,                  // One-cycle write of a good packet
  output logic              packet_drop,                 // One-cycle pulse per discarded packet
  output spio_pkg::packet_t packet                       // Packet under assembly
);

  typedef enum logic [1:0] {
    ST_FLUSH,                                            // Let the synchronizer fill
    ST_READY,                                            // First ack tells the sender we are up
    ST_ASSEMBLE,                                         // Collect nibbles until EOP
    ST_RESYNC                                            // Discard until EOP
  } state_t;

  state_t          state;
  logic            flush_done;                           // Second flush cycle reached
  spio_pkg::code_t last_code;                            // Code at the last ack
  logic [4:0]      symbol_count;                         // Data symbols in this packet
  logic            long_packet;                          // From bit 1 of the first nibble

  logic [3:0]      nibble;
  logic            eop;
  logic            oob;
  logic            tom;

  logic            good_length;                          // Count fits the packet kind
  logic            overrun;                              // One symbol more than allowed
  logic            accept;                               // Ack the symbol on this edge
  logic            take_nibble;                          // Data symbol in assembly

  //////////////////////////////////////////////////
  // Symbol decode and accept logic
  //////////////////////////////////////////////////
  always_comb begin
    spio_pkg::decode_symbol(sync_code ^ last_code, nibble, eop, oob, tom);
  end

  assign good_length = long_packet ? (symbol_count == 5'(spio_pkg::LONG_SYMBOLS))
                                   : (symbol_count == 5'(spio_pkg::SHORT_SYMBOLS));
  assign overrun     = long_packet ? (symbol_count >= 5'(spio_pkg::LONG_SYMBOLS))
                                   : (symbol_count >= 5'(spio_pkg::SHORT_SYMBOLS));

  always_comb begin
    case (state)
      ST_READY:    accept = 1'b1;
      ST_ASSEMBLE: accept = tom & ~(eop & good_length & fifo_full); // Stall a good EOP when full
      ST_RESYNC:   accept = tom;
      default:     accept = 1'b0;
    endcase
  end

  assign take_nibble = (state == ST_ASSEMBLE) & tom & ~eop & ~oob;

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state        <= ST_FLUSH;
      flush_done   <= 1'b0;
      last_code    <= '0;
      data_ack     <= 1'b0;
      fifo_write   <= 1'b0;
      packet_drop  <= 1'b0;
      symbol_count <= '0;
      long_packet  <= 1'b0;
    end else begin
      fifo_write  <= 1'b0;                               // Pulses by default
      packet_drop <= 1'b0;
      if (accept) begin
        data_ack  <= ~data_ack;                          // Release the sender
        last_code <= sync_code;                          // New reference for the next symbol
      end
      case (state)
        ST_FLUSH: begin
          flush_done <= 1'b1;
          if (flush_done) state <= ST_READY;             // Two cycles spent
        end
        ST_READY: begin
          state <= ST_ASSEMBLE;                          // Ack toggled above
        end
        ST_ASSEMBLE: begin
          if (eop) begin
            if (!good_length) begin                      // Wrong length, discard
              packet_drop  <= 1'b1;
              symbol_count <= '0;
            end else if (!fifo_full) begin               // Good packet with room
              fifo_write   <= 1'b1;
              symbol_count <= '0;
            end
          end else if (oob) begin                        // Bad symbol, lose the packet
            packet_drop  <= 1'b1;
            symbol_count <= '0;
            state        <= ST_RESYNC;
          end else if (tom) begin
            if (symbol_count == 5'd0) long_packet <= nibble[1];
            if (overrun) begin                           // Too many symbols
              packet_drop  <= 1'b1;
              symbol_count <= '0;
              state        <= ST_RESYNC;
            end else begin
              symbol_count <= symbol_count + 5'd1;
            end
          end
        end
        ST_RESYNC: begin
          if (eop) state <= ST_ASSEMBLE;                 // Already counted as one drop
        end
        default: state <= ST_FLUSH;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Packet shift register
  //////////////////////////////////////////////////
  // Newest nibble enters at the top, so nibble 0 ends in bits 3:0
  always_ff @(posedge clk) begin
    if (take_nibble) begin
      if (symbol_count < 5'(spio_pkg::SHORT_SYMBOLS)) begin
        packet[39:0] <= {nibble, packet[39:4]};          // Header and key
        if (symbol_count == 5'd0) packet[71:40] <= '0;   // Short packet reads zero above
      end else begin
        packet[71:40] <= {nibble, packet[71:44]};        // Payload
      end
    end
  end

endmodule

// ==== source/spio_packet_fifo.sv ====
`timescale 1ns/1ps

module spio_packet_fifo #(
  parameter int FIFO_DEPTH_LOG2 = 2                      // Depth is a power of two
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              fifo_write,                  // Push packet
  input  spio_pkg::packet_t packet,
  input  logic              fifo_read,                   // Pop head
  output spio_pkg::packet_t head,                        // Oldest packet, fall-through
  output logic              fifo_full,
  output logic              fifo_empty
);

  localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

  spio_pkg::packet_t          mem [DEPTH];
  logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
  logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
  logic [FIFO_DEPTH_LOG2:0]   count;                     // One bit wider to reach DEPTH

  logic do_write;
  logic do_read;

  assign fifo_full  = (count == (FIFO_DEPTH_LOG2 + 1)'(DEPTH));
  assign fifo_empty = (count == '0);
  assign do_write   = fifo_write & ~fifo_full;           // Write when full is ignored
  assign do_read    = fifo_read & ~fifo_empty;           // Read when empty is ignored

  //////////////////////////////////////////////////
  // Pointers and occupancy
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) wr_ptr <= wr_ptr + 1'b1;             // Wraps at DEPTH
      if (do_read)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                         // Both or neither
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (do_write) mem[wr_ptr] <= packet;
  end

  assign head = mem[rd_ptr];                             // Valid whenever not empty

endmodule

// ==== source/spio_wb_packet_port.sv ====
`timescale 1ns/1ps

module spio_wb_packet_port #(
  parameter int DROP_COUNT_WIDTH = 8                     // Drop counter width
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [1:0]        wb_adr,                      // Word address
  input  logic [31:0]       wb_wdata,
  output logic [31:0]       wb_rdata,
  output logic              wb_ack,
  input  logic              packet_drop,                 // Pulse per discarded packet
  input  spio_pkg::packet_t head,
  input  logic              fifo_empty,
  input  logic              fifo_full,
  output logic              fifo_read                    // Pop on word-2 acknowledge
);

  logic [DROP_COUNT_WIDTH-1:0] drop_count;
  logic [7:0]                  drop_field;               // Status bits 15:8
  logic                        request;                  // New cycle this clock
  logic                        pop_pending;              // Current ack ends a word-2 read
  logic [31:0]                 read_word;
  logic                        clear_drops;

  assign request     = wb_cyc & wb_stb & ~wb_ack;        // One ack per strobe
  assign clear_drops = request & wb_we & (wb_adr == spio_pkg::ADR_STATUS);
  assign drop_field  = 8'(drop_count);

  //////////////////////////////////////////////////
  // Register read mux
  //////////////////////////////////////////////////
  always_comb begin
    read_word = '0;
    case (wb_adr)
      spio_pkg::ADR_STATUS: read_word = {16'd0, drop_field, 6'd0, fifo_full, ~fifo_empty};
      spio_pkg::ADR_WORD0:  if (!fifo_empty) read_word = head[31:0];
      spio_pkg::ADR_WORD1:  if (!fifo_empty) read_word = head[63:32];
      default:              if (!fifo_empty) read_word = {24'd0, head[71:64]};
    endcase
  end

  //////////////////////////////////////////////////
  // Acknowledge and read data
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_ack      <= 1'b0;
      pop_pending <= 1'b0;
    end else begin
      wb_ack      <= request;                            // Single-cycle classic ack
      pop_pending <= request & ~wb_we & (wb_adr == spio_pkg::ADR_WORD2) & ~fifo_empty;
    end
  end

  always_ff @(posedge clk) begin
    if (request) wb_rdata <= wb_we ? wb_wdata : read_word; // Writes echo the bus data
  end

  assign fifo_read = wb_ack & pop_pending;               // Pop lands on the ack edge

  //////////////////////////////////////////////////
  // Dropped-packet counter
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      drop_count <= '0;
    end else if (clear_drops) begin
      drop_count <= '0;                                  // Status write clears
    end else if (packet_drop && (drop_count != '1)) begin
      drop_count <= drop_count + 1'b1;                   // Saturates at all ones
    end
  end

endmodule

// ==== source/spio_link_rx.sv ====
`timescale 1ns/1ps

module spio_link_rx #(
  parameter int SYNC_STAGES      = 2,                    // Synchronizer depth
  parameter int FIFO_DEPTH_LOG2  = 2,                    // FIFO holds 2^N packets
  parameter int DROP_COUNT_WIDTH = 8                     // Drop counter width
) (
  input  logic            clk,
  input  logic            reset,
  input  spio_pkg::code_t data_2of7,                     // Link wires in
  output logic            data_ack,                      // Link ack out
  input  logic            wb_cyc,
  input  logic            wb_stb,
  input  logic            wb_we,
  input  logic [1:0]      wb_adr,
  input  logic [31:0]     wb_wdata,
  output logic [31:0]     wb_rdata,
  output logic            wb_ack
);

  spio_pkg::code_t   sync_code;
  spio_pkg::packet_t packet;
  spio_pkg::packet_t head;
  logic              fifo_write;
  logic              fifo_read;
  logic              fifo_full;
  logic              fifo_empty;
  logic              packet_drop;

  //////////////////////////////////////////////////
  // Stage chain
  //////////////////////////////////////////////////
  spio_link_sync #(.SYNC_STAGES(SYNC_STAGES)) u_sync (
    .clk, .reset, .data_2of7, .sync_code
  );

  spio_packet_assembler u_assembler (
    .clk, .reset, .sync_code, .fifo_full, .data_ack, .fifo_write, .packet_drop, .packet
  );

  spio_packet_fifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_fifo (
    .clk, .reset, .fifo_write, .packet, .fifo_read, .head, .fifo_full, .fifo_empty
  );

  spio_wb_packet_port #(.DROP_COUNT_WIDTH(DROP_COUNT_WIDTH)) u_wb_port (
    .clk, .reset,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata, .wb_ack,
    .packet_drop, .head, .fifo_empty, .fifo_full, .fifo_read
  );

endmodule

// ==== testbench/spio_link_rx_tb.sv ====
`timescale 1ns/1ps

module spio_link_rx_tb;

  localparam int SYNC_STAGES      = 2;
  localparam int FIFO_DEPTH_LOG2  = 2;
  localparam int DROP_COUNT_WIDTH = 8;
  localparam int DEPTH            = 1 << FIFO_DEPTH_LOG2;
  localparam int ACK_TIMEOUT      = 50;                  // Cycles allowed per link symbol
  localparam int STALL_WINDOW     = 40;                  // EOP must stay unacked this long
  localparam int WB_TIMEOUT       = 20;                  // Cycles allowed per bus cycle
  localparam spio_pkg::code_t OOB_CODE = 7'b0000111;     // Three wires at once

  typedef enum logic {KIND_SHORT, KIND_LONG} kind_e;
  typedef enum logic [1:0] {FAULT_NONE, FAULT_LENGTH, FAULT_OOB} fault_e;

  typedef struct {
    string  name;
    kind_e  kind;
    fault_e fault;
    int     fault_at;                                    // Symbol index of the OOB transition
    bit     read_now;                                    // Drain the FIFO after this packet
    bit     clear_drops;                                 // Status write afterwards
    bit     stall;                                       // EOP waits for FIFO space
    int     drop_delta;                                  // Expected rise of the drop count
  } entry_t;

  logic              clk;
  logic              reset;
  spio_pkg::code_t   data_2of7;
  logic              data_ack;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [1:0]        wb_adr;
  logic [31:0]       wb_wdata;
  logic [31:0]       wb_rdata;
  logic              wb_ack;

  entry_t            stimulus [13];
  spio_pkg::packet_t expected_q [$];                     // Stored packets in send order
  int                drop_count_exp;
  logic [31:0]       rng;
  logic              ack_level;                          // Last data_ack level seen

  spio_link_rx #(
    .SYNC_STAGES(SYNC_STAGES),
    .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2),
    .DROP_COUNT_WIDTH(DROP_COUNT_WIDTH)
  ) dut (
    .clk, .reset, .data_2of7, .data_ack,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata, .wb_ack
  );

  always #10 clk = ~clk;                                 // 20 ns period

  //////////////////////////////////////////////////
  // Helpers and checks
  //////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] status_word(input int pending, input int drops);
    logic [31:0] w;
    w       = '0;
    w[0]    = (pending > 0);                             // Not empty
    w[1]    = (pending == DEPTH);                        // Full
    w[15:8] = 8'(drops);
    return w;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_packet(input string name, input spio_pkg::packet_t expected,
                              input spio_pkg::packet_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // One classic cycle whose ack must come and last one clock
  task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int c;
    bit got;
    got = 1'b0;
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_wdata = wdata;
    for (c = 0; c < WB_TIMEOUT && !got; c++) begin
      @(posedge clk);
      #1;
      got = wb_ack;
    end
    if (!got) fail_run("Wishbone cycle was never acknowledged");
    rdata  = wb_rdata;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge clk);
    #1;
    if (wb_ack) fail_run("wb_ack stayed high for a second clock");
  endtask

  task automatic check_status(input string name);
    logic [31:0] w;
    bus_cycle(1'b0, spio_pkg::ADR_STATUS, '0, w);
    check_word(name, status_word(expected_q.size(), drop_count_exp), w);
  endtask

  task automatic read_head_packet(input string name);
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    bus_cycle(1'b0, spio_pkg::ADR_WORD0, '0, w0);
    bus_cycle(1'b0, spio_pkg::ADR_WORD1, '0, w1);
    bus_cycle(1'b0, spio_pkg::ADR_WORD2, '0, w2);        // Pops on the ack
    check_word({name, "/word2_upper"}, 32'h0, w2 & 32'hffff_ff00);
    check_packet(name, expected_q.pop_front(), {w2[7:0], w1, w0});
  endtask

  //////////////////////////////////////////////////
  // Link transmitter model
  //////////////////////////////////////////////////
  task automatic drive_symbol(input spio_pkg::code_t code);
    @(posedge clk);
    #1;
    data_2of7 = data_2of7 ^ code;                        // Transition coding
  endtask

  task automatic wait_link_ack(input int limit, output bit seen);
    int c;
    seen = 1'b0;
    for (c = 0; c < limit && !seen; c++) begin
      @(posedge clk);
      #1;
      if (data_ack !== ack_level) begin
        ack_level = data_ack;
        seen      = 1'b1;
      end
    end
  endtask

  task automatic send_symbol(input spio_pkg::code_t code, input string what);
    bit seen;
    drive_symbol(code);
    wait_link_ack(ACK_TIMEOUT, seen);
    if (!seen) fail_run($sformatf("No data_ack toggle after %s", what));
  endtask

  task automatic run_entry(input entry_t e);
    logic [3:0]        nibbles [18];
    spio_pkg::packet_t expected;
    logic [31:0]       w;
    int                count;
    int                sent;
    int                i;
    bit                seen;
    count    = (e.kind == KIND_LONG) ? spio_pkg::LONG_SYMBOLS : spio_pkg::SHORT_SYMBOLS;
    sent     = (e.fault == FAULT_LENGTH) ? count - 3 : count;
    expected = '0;
    for (i = 0; i < count; i++) begin
      rng        = xorshift32(rng);
      nibbles[i] = rng[3:0];
    end
    nibbles[0][1] = (e.kind == KIND_LONG);               // Long flag in the first nibble
    for (i = 0; i < count; i++) begin
      expected[4*i +: 4] = nibbles[i];                   // First nibble lowest
    end
    for (i = 0; i < sent; i++) begin
      if (e.fault == FAULT_OOB && i == e.fault_at) send_symbol(OOB_CODE, "OOB symbol");
      send_symbol(spio_pkg::nibble_code(nibbles[i]), $sformatf("%s symbol %0d", e.name, i));
    end
    if (e.stall) begin
      drive_symbol(spio_pkg::EOP_CODE);
      wait_link_ack(STALL_WINDOW, seen);
      if (seen) fail_run("EOP was acknowledged while the FIFO was full");
      read_head_packet({e.name, "/head_during_stall"});  // Frees one slot
      wait_link_ack(ACK_TIMEOUT, seen);
      if (!seen) fail_run("Stalled EOP was not acknowledged after a FIFO pop");
    end else begin
      send_symbol(spio_pkg::EOP_CODE, {e.name, " EOP"});
    end
    if (e.drop_delta == 0) expected_q.push_back(expected);
    drop_count_exp += e.drop_delta;
    check_status({e.name, "/status"});
    if (e.read_now) begin
      while (expected_q.size() > 0) read_head_packet({e.name, "/packet"});
      check_status({e.name, "/status_after_read"});
    end
    if (e.clear_drops) begin
      bus_cycle(1'b1, spio_pkg::ADR_STATUS, 32'h0, w);
      drop_count_exp = 0;
      check_status({e.name, "/status_after_clear"});
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus table and main sequence
  //////////////////////////////////////////////////
  initial begin
    bit          seen;
    logic [31:0] w;
    clk = 1'b0;
    reset = 1'b1;
    data_2of7 = '0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_wdata = '0;
    rng = 32'h3428;
    ack_level = 1'b0;
    drop_count_exp = 0;
    // name, kind, fault, fault_at, read_now, clear_drops, stall, drop_delta
    stimulus[0]  = '{"short_basic", KIND_SHORT, FAULT_NONE, 0, 1'b1, 1'b0, 1'b0, 0};
    stimulus[1]  = '{"long_basic", KIND_LONG, FAULT_NONE, 0, 1'b1, 1'b0, 1'b0, 0};
    stimulus[2]  = '{"short_bad_length", KIND_SHORT, FAULT_LENGTH, 0, 1'b1, 1'b0, 1'b0, 1};
    stimulus[3]  = '{"long_after_bad_length", KIND_LONG, FAULT_NONE, 0, 1'b1, 1'b1, 1'b0, 0};
    stimulus[4]  = '{"long_oob", KIND_LONG, FAULT_OOB, 6, 1'b1, 1'b0, 1'b0, 1};
    stimulus[5]  = '{"short_after_oob", KIND_SHORT, FAULT_NONE, 0, 1'b1, 1'b0, 1'b0, 0};
    stimulus[6]  = '{"long_bad_length", KIND_LONG, FAULT_LENGTH, 0, 1'b1, 1'b1, 1'b0, 1};
    stimulus[7]  = '{"fill_0", KIND_SHORT, FAULT_NONE, 0, 1'b0, 1'b0, 1'b0, 0};
    stimulus[8]  = '{"fill_1", KIND_LONG, FAULT_NONE, 0, 1'b0, 1'b0, 1'b0, 0};
    stimulus[9]  = '{"fill_2", KIND_SHORT, FAULT_NONE, 0, 1'b0, 1'b0, 1'b0, 0};
    stimulus[10] = '{"fill_3", KIND_LONG, FAULT_NONE, 0, 1'b0, 1'b0, 1'b0, 0};
    stimulus[11] = '{"fill_stall", KIND_SHORT, FAULT_NONE, 0, 1'b1, 1'b0, 1'b1, 0};
    stimulus[12] = '{"oob_first_symbol", KIND_SHORT, FAULT_OOB, 0, 1'b1, 1'b1, 1'b0, 1};
    repeat (10) @(posedge clk);
    #1;
    if (data_ack !== 1'b0 || wb_ack !== 1'b0) fail_run("Control outputs not low in reset");
    reset = 1'b0;
    wait_link_ack(ACK_TIMEOUT, seen);                    // Ready toggle after the flush
    if (!seen) fail_run("Receiver never signalled ready on data_ack");
    check_status("after_reset");
    foreach (stimulus[k]) run_entry(stimulus[k]);
    bus_cycle(1'b0, spio_pkg::ADR_WORD0, '0, w);         // Empty FIFO reads zero
    check_word("empty_word0", 32'h0, w);
    bus_cycle(1'b0, spio_pkg::ADR_WORD2, '0, w);         // No pop when empty
    check_word("empty_word2", 32'h0, w);
    check_status("final_status");
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== vlog.f ====
source/spio_pkg.sv
source/spio_link_sync.sv
source/spio_packet_assembler.sv
source/spio_packet_fifo.sv
source/spio_wb_packet_port.sv
source/spio_link_rx.sv
testbench/spio_link_rx_tb.sv

// ==== Makefile ====
# Verilator flow for the 2-of-7 link receiver
# Any variable can be overridden, e.g. make sim JOBS=8

VERILATOR  ?= verilator
FILELIST   ?= vlog.f
TB_TOP     ?= spio_link_rx_tb
RTL_TOP    ?= spio_link_rx
BUILD_DIR  ?= obj_dir
JOBS       ?= 4
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing

.PHONY: all lint sim clean

all: sim

# Lint the RTL top level only
lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# Build and run; a $$fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(SIM_FLAGS) -j $(JOBS) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)
